//--- src.f
l2_pkg.sv
l2_rr_arbiter.sv
l2_xbar.sv
l2_bank.sv
l2_subsystem.sv
l2_tb_clk.sv
l2_chk.sv
l2_tb.sv

//--- Makefile
# Verilator build and run of the L2 subsystem testbench

TOP := l2_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) \
		-Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	@if grep -q "TEST RESULT: PASS" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- l2_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 subsystem testbench
// Directed tests for access, byte enables, window aliasing,
// bank parallelism, arbitration fairness and random traffic
// checked against a word model of the shared memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module l2_tb;
  import l2_pkg::*;

  localparam int unsigned NB_BANKS      = 4;
  localparam int unsigned BANK_WORDS    = 1024;
  localparam int unsigned MEM_WORDS     = NB_BANKS * BANK_WORDS;
  localparam int unsigned DRAIN_TIMEOUT = 50;
  localparam int unsigned RST_TIMEOUT   = 50;
  localparam addr_t       RND_BASE      = 32'h800;  // Small region for random traffic
  localparam int unsigned RND_WORDS     = 32;

  logic clk;
  logic rst_n;

  master_vec_t           req, wen, gnt, r_valid;
  addr_t [N_MASTERS-1:0] add;
  data_t [N_MASTERS-1:0] wdata, r_rdata;
  be_t   [N_MASTERS-1:0] be;

  // Outstanding request per master
  master_vec_t pend, p_wr;
  addr_t       p_off  [N_MASTERS];
  data_t       p_data [N_MASTERS];
  be_t         p_be   [N_MASTERS];
  int unsigned p_wait [N_MASTERS];

  master_vec_t exp_valid;               // Responses due next cycle
  data_t       exp_data [N_MASTERS];
  data_t       ref_mem  [MEM_WORDS];    // Indexed by word offset
  int unsigned n_gnt;                   // Grants seen in the latest cycle
  integer      seed;
  string       test_name;

  l2_tb_clk i_l2_tb_clk (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  l2_subsystem #(
    .NB_BANKS   ( NB_BANKS   ),
    .BANK_WORDS ( BANK_WORDS )
  ) i_l2_subsystem (
    .clk_i     ( clk     ),
    .rst_n_i   ( rst_n   ),
    .req_i     ( req     ),
    .add_i     ( add     ),
    .wen_i     ( wen     ),
    .wdata_i   ( wdata   ),
    .be_i      ( be      ),
    .gnt_o     ( gnt     ),
    .r_valid_o ( r_valid ),
    .r_rdata_o ( r_rdata )
  );

  task automatic abort_run(input string reason);
    $display("error %s: %s", test_name, reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("%s expected %h actual %h", what, expected, actual));
    end
  endtask

  function automatic addr_t window_base(input int unsigned m);
    return (m < N_BRIDGE_PORTS) ? L2_BRIDGE_BASE : L2_UDMA_BASE;
  endfunction

  function automatic int unsigned word_index(input addr_t off);
    return (off >> 2) % MEM_WORDS;
  endfunction

  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input be_t m);
    data_t res;
    res = old_w;
    for (int unsigned i = 0; i < BE_W; i++) begin
      if (m[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

  task automatic post(input int unsigned m, input bit wr, input addr_t off,
                      input data_t d, input be_t b);
    pend[m]   = 1'b1;
    p_wr[m]   = wr;
    p_off[m]  = off;
    p_data[m] = d;
    p_be[m]   = b;
    p_wait[m] = 0;
  endtask

  // One clock of response checks, requests and grant bookkeeping
  task automatic step_cycle();
    int unsigned idx;
    @(negedge clk);
    for (int unsigned m = 0; m < N_MASTERS; m++) begin
      check_value($sformatf("r_valid[%0d]", m), 32'(exp_valid[m]), 32'(r_valid[m]));
      if (exp_valid[m]) check_value($sformatf("r_rdata[%0d]", m), exp_data[m], r_rdata[m]);
    end
    for (int unsigned m = 0; m < N_MASTERS; m++) begin
      req[m]   = pend[m];
      add[m]   = p_off[m] + window_base(m);
      wen[m]   = !p_wr[m];  // Low means write
      wdata[m] = p_data[m];
      be[m]    = p_be[m];
    end
    #1;  // Grant is combinational and stable until the rising edge
    exp_valid = '0;
    n_gnt     = 0;
    // Order does not matter since a word is granted at most once per cycle
    for (int unsigned m = 0; m < N_MASTERS; m++) begin
      if (gnt[m] && !pend[m]) begin
        abort_run($sformatf("grant to master %0d without a request", m));
      end else if (gnt[m]) begin
        idx          = word_index(p_off[m]);
        exp_valid[m] = 1'b1;
        n_gnt++;
        if (p_wr[m]) begin
          exp_data[m]  = '0;
          ref_mem[idx] = merge_bytes(ref_mem[idx], p_data[m], p_be[m]);
        end else begin
          exp_data[m] = ref_mem[idx];
        end
        pend[m] = 1'b0;
      end else if (pend[m]) begin
        p_wait[m]++;
        if (p_wait[m] >= N_MASTERS) abort_run($sformatf("master %0d starved", m));
      end
    end
  endtask

  task automatic drain();
    int unsigned cycles;
    cycles = 0;
    do begin
      step_cycle();
      cycles++;
    end while ((pend != '0 || exp_valid != '0) && cycles < DRAIN_TIMEOUT);
    if (pend != '0 || exp_valid != '0) abort_run("accesses did not complete in time");
  endtask

  task automatic basic_access();
    addr_t off;
    test_name = "basic_access";
    for (int unsigned m = 0; m < N_MASTERS; m++) begin
      off = 32'h100 + m * 32'h20;
      post(m, 1'b1, off, $random(seed), 4'hF);
      drain();
      post(m, 1'b0, off, '0, 4'hF);
      drain();
    end
  endtask

  task automatic byte_enable_writes();
    be_t masks [3] = '{4'b0001, 4'b0110, 4'b1000};
    test_name = "byte_enable_writes";
    post(2, 1'b1, 32'h200, 32'h1122_3344, 4'hF);
    drain();
    for (int unsigned i = 0; i < 3; i++) begin
      post(2, 1'b1, 32'h200, $random(seed), masks[i]);
      drain();
      post(2, 1'b0, 32'h200, '0, 4'hF);
      drain();
    end
  endtask

  task automatic window_aliasing();
    test_name = "window_aliasing";
    post(1, 1'b1, 32'h340, $random(seed), 4'hF);  // Bridge writes and uDMA reads
    drain();
    post(4, 1'b0, 32'h340, '0, 4'hF);
    drain();
    post(5, 1'b1, 32'h384, $random(seed), 4'hF);  // And the other way
    drain();
    post(3, 1'b0, 32'h384, '0, 4'hF);
    drain();
  endtask

  task automatic parallel_banks();
    test_name = "parallel_banks";
    for (int unsigned pass = 0; pass < 2; pass++) begin
      for (int unsigned m = 0; m < 4; m++) begin
        post(m, pass == 0, 32'h400 + 4 * m, $random(seed), 4'hF);
      end
      step_cycle();
      check_value("grants in first cycle", 32'd4, n_gnt);
      drain();
    end
  endtask

  task automatic bank_conflict();
    test_name = "bank_conflict";
    for (int unsigned pass = 0; pass < 2; pass++) begin
      // Stride of NB_BANKS words keeps every master on bank 0
      for (int unsigned m = 0; m < N_MASTERS; m++) begin
        post(m, pass == 0, 32'h500 + m * 16, $random(seed), 4'hF);
      end
      repeat (N_MASTERS) begin
        step_cycle();
        check_value("grants per cycle", 32'd1, n_gnt);
      end
      check_value("masters still waiting", 32'd0, 32'(pend));
      drain();
    end
  endtask

  task automatic random_traffic();
    logic [31:0] r;
    test_name = "random_traffic";
    for (int unsigned w = 0; w < RND_WORDS; w++) begin
      post(w % N_MASTERS, 1'b1, RND_BASE + 4 * w, $random(seed), 4'hF);  // No X reads later
      drain();
    end
    for (int unsigned c = 0; c < 200; c++) begin
      for (int unsigned m = 0; m < N_MASTERS; m++) begin
        r = $random(seed);
        if (!pend[m] && r[0]) post(m, r[1], RND_BASE + (r & 32'h7C), $random(seed), r[11:8]);
      end
      step_cycle();
    end
    drain();
  endtask

  initial begin
    int unsigned cycles;
    seed      = 67;
    test_name = "reset";
    req       = '0;
    wen       = '1;
    add       = '0;
    wdata     = '0;
    be        = '0;
    pend      = '0;
    p_wr      = '0;
    exp_valid = '0;
    n_gnt     = 0;
    for (int unsigned m = 0; m < N_MASTERS; m++) begin
      p_off[m]    = '0;
      p_data[m]   = '0;
      p_be[m]     = '0;
      p_wait[m]   = 0;
      exp_data[m] = '0;
    end
    cycles = 0;
    while (!rst_n && cycles < RST_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!rst_n) abort_run("reset was never released");
    basic_access();
    byte_enable_writes();
    window_aliasing();
    parallel_banks();
    bank_conflict();
    random_traffic();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- l2_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 subsystem protocol assertions
// Response timing, reset values and one grant per bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module l2_chk #(
  parameter int unsigned NB_BANKS = 4
) (
  input logic                                  clk_i,
  input logic                                  rst_n_i,
  input l2_pkg::addr_t [l2_pkg::N_MASTERS-1:0] add_i,
  input l2_pkg::master_vec_t                   gnt_i,
  input l2_pkg::master_vec_t                   r_valid_i,
  input l2_pkg::master_vec_t [NB_BANKS-1:0]    bank_gnt_i  // Per-bank arbiter grants
);
  import l2_pkg::*;

  addr_t       [N_MASTERS-1:0] off;       // Address relative to the master's window
  master_vec_t [NB_BANKS-1:0]  bank_hit;  // Masters whose word falls in each bank

  always_comb begin
    for (int unsigned m = 0; m < N_MASTERS; m++) begin
      off[m] = add_i[m] - ((m < N_BRIDGE_PORTS) ? L2_BRIDGE_BASE : L2_UDMA_BASE);
    end
    for (int unsigned b = 0; b < NB_BANKS; b++) begin
      for (int unsigned m = 0; m < N_MASTERS; m++) begin
        bank_hit[b][m] = ((off[m] >> 2) % NB_BANKS) == b;
      end
    end
  end

  // Writes also answer exactly one cycle after the grant
  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_i == $past(gnt_i))
    else $error("r_valid is not the grant of the previous cycle");

  a_quiet_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |-> (gnt_i == '0 && r_valid_i == '0))
    else $error("gnt or r_valid high during reset");

  // The bank winner is the only granted master addressing that bank
  for (genvar b = 0; b < NB_BANKS; b++) begin : gen_bank_chk
    a_one_winner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(bank_gnt_i[b]) && ((gnt_i & bank_hit[b]) == bank_gnt_i[b]))
      else $error("bank %0d grants do not match one granted master", b);
  end

endmodule

bind l2_subsystem l2_chk #(.NB_BANKS(NB_BANKS)) i_l2_chk (
  .clk_i      ( clk_i               ),
  .rst_n_i    ( rst_n_i             ),
  .add_i      ( add_i               ),
  .gnt_i      ( gnt_o               ),
  .r_valid_i  ( r_valid_o           ),
  .bank_gnt_i ( i_l2_xbar.bank_gnt  )
);

`default_nettype wire

//--- l2_tb_clk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 testbench clock and reset
// Free-running clock and an active-low reset held for a
// fixed number of cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module l2_tb_clk #(
  parameter int unsigned PERIOD_NS  = 10,
  parameter int unsigned RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;  // Released away from the active edge
  end

endmodule

`default_nettype wire

//--- l2_subsystem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 scratchpad subsystem
// Four bridge ports and two uDMA channels share NB_BANKS
// word-interleaved SRAM banks through one crossbar
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module l2_subsystem #(
  parameter  int unsigned NB_BANKS    = 4,
  parameter  int unsigned BANK_WORDS  = 1024,
  localparam int unsigned BANK_ADDR_W = $clog2(BANK_WORDS)
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  l2_pkg::master_vec_t                   req_i,    // 0..3 bridge, 4..5 uDMA
  input  l2_pkg::addr_t [l2_pkg::N_MASTERS-1:0] add_i,
  input  l2_pkg::master_vec_t                   wen_i,
  input  l2_pkg::data_t [l2_pkg::N_MASTERS-1:0] wdata_i,
  input  l2_pkg::be_t   [l2_pkg::N_MASTERS-1:0] be_i,
  output l2_pkg::master_vec_t                   gnt_o,
  output l2_pkg::master_vec_t                   r_valid_o,
  output l2_pkg::data_t [l2_pkg::N_MASTERS-1:0] r_rdata_o
);
  import l2_pkg::*;

  logic  [NB_BANKS-1:0]                  bank_req;
  logic  [NB_BANKS-1:0]                  bank_wen;
  logic  [NB_BANKS-1:0][BANK_ADDR_W-1:0] bank_addr;
  data_t [NB_BANKS-1:0]                  bank_wdata;
  be_t   [NB_BANKS-1:0]                  bank_be;
  data_t [NB_BANKS-1:0]                  bank_rdata;

  l2_xbar #(
    .NB_BANKS   ( NB_BANKS   ),
    .BANK_WORDS ( BANK_WORDS )
  ) i_l2_xbar (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .req_i        ( req_i      ),
    .add_i        ( add_i      ),
    .wen_i        ( wen_i      ),
    .wdata_i      ( wdata_i    ),
    .be_i         ( be_i       ),
    .gnt_o        ( gnt_o      ),
    .r_valid_o    ( r_valid_o  ),
    .r_rdata_o    ( r_rdata_o  ),
    .bank_req_o   ( bank_req   ),
    .bank_wen_o   ( bank_wen   ),
    .bank_addr_o  ( bank_addr  ),
    .bank_wdata_o ( bank_wdata ),
    .bank_be_o    ( bank_be    ),
    .bank_rdata_i ( bank_rdata )
  );

  // Banks accept every request, so no bank grant is needed
  for (genvar b = 0; b < NB_BANKS; b++) begin : gen_bank
    l2_bank #(
      .BANK_WORDS ( BANK_WORDS )
    ) i_l2_bank (
      .clk_i   ( clk_i         ),
      .req_i   ( bank_req[b]   ),
      .wen_i   ( bank_wen[b]   ),
      .addr_i  ( bank_addr[b]  ),
      .wdata_i ( bank_wdata[b] ),
      .be_i    ( bank_be[b]    ),
      .rdata_o ( bank_rdata[b] )
    );
  end

endmodule

`default_nettype wire

//--- l2_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 SRAM bank
// Single-port word memory, byte-enable writes and
// registered read data one cycle after the request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module l2_bank #(
  parameter  int unsigned BANK_WORDS  = 1024,
  localparam int unsigned BANK_ADDR_W = $clog2(BANK_WORDS)
) (
  input  logic                   clk_i,
  input  logic                   req_i,
  input  logic                   wen_i,    // Active low write enable
  input  logic [BANK_ADDR_W-1:0] addr_i,
  input  l2_pkg::data_t          wdata_i,
  input  l2_pkg::be_t            be_i,
  output l2_pkg::data_t          rdata_o
);
  import l2_pkg::*;

  data_t mem_q [BANK_WORDS];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (!wen_i) begin
        // Only the enabled bytes change
        for (int unsigned i = 0; i < BE_W; i++) begin
          if (be_i[i]) begin
            mem_q[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];  // Holds until the next read
      end
    end
  end

endmodule

`default_nettype wire

//--- l2_xbar.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 request crossbar
// Rebases master addresses, picks bank and row, arbitrates
// each bank and returns responses one cycle after the grant
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module l2_xbar #(
  parameter  int unsigned NB_BANKS    = 4,     // Power of two, at least 2
  parameter  int unsigned BANK_WORDS  = 1024,  // Power of two
  localparam int unsigned BANK_ADDR_W = $clog2(BANK_WORDS),
  localparam int unsigned BANK_SEL_W  = $clog2(NB_BANKS)
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  // Master side
  input  l2_pkg::master_vec_t                   req_i,
  input  l2_pkg::addr_t [l2_pkg::N_MASTERS-1:0] add_i,
  input  l2_pkg::master_vec_t                   wen_i,
  input  l2_pkg::data_t [l2_pkg::N_MASTERS-1:0] wdata_i,
  input  l2_pkg::be_t   [l2_pkg::N_MASTERS-1:0] be_i,
  output l2_pkg::master_vec_t                   gnt_o,
  output l2_pkg::master_vec_t                   r_valid_o,
  output l2_pkg::data_t [l2_pkg::N_MASTERS-1:0] r_rdata_o,
  // Bank side
  output logic          [NB_BANKS-1:0]                  bank_req_o,
  output logic          [NB_BANKS-1:0]                  bank_wen_o,
  output logic          [NB_BANKS-1:0][BANK_ADDR_W-1:0] bank_addr_o,
  output l2_pkg::data_t [NB_BANKS-1:0]                  bank_wdata_o,
  output l2_pkg::be_t   [NB_BANKS-1:0]                  bank_be_o,
  input  l2_pkg::data_t [NB_BANKS-1:0]                  bank_rdata_i
);
  import l2_pkg::*;

  localparam int unsigned MST_W   = $clog2(N_MASTERS);
  localparam int unsigned ROW_LSB = 2 + BANK_SEL_W;  // Above byte and bank bits

  addr_t [N_MASTERS-1:0]                  offset;
  logic  [N_MASTERS-1:0][BANK_SEL_W-1:0]  mst_bank;
  logic  [N_MASTERS-1:0][BANK_ADDR_W-1:0] mst_row;

  master_vec_t [NB_BANKS-1:0]             bank_mreq;  // Masters targeting each bank
  master_vec_t [NB_BANKS-1:0]             bank_gnt;   // Arbiter result per bank
  logic        [NB_BANKS-1:0][MST_W-1:0]  gnt_idx;

  // Response record, one entry per bank
  logic [NB_BANKS-1:0]            rsp_valid_q;
  logic [NB_BANKS-1:0]            rsp_read_q;
  logic [NB_BANKS-1:0][MST_W-1:0] rsp_mst_q;

  // Bridge and uDMA windows both map onto offset zero
  always_comb begin
    for (int unsigned m = 0; m < N_MASTERS; m++) begin
      offset[m]   = add_i[m] - ((m < N_BRIDGE_PORTS) ? L2_BRIDGE_BASE : L2_UDMA_BASE);
      mst_bank[m] = offset[m][2 +: BANK_SEL_W];          // Word interleaved
      mst_row[m]  = offset[m][ROW_LSB +: BANK_ADDR_W];   // Wraps modulo bank size
    end
  end

  always_comb begin
    for (int unsigned b = 0; b < NB_BANKS; b++) begin
      for (int unsigned m = 0; m < N_MASTERS; m++) begin
        bank_mreq[b][m] = req_i[m] && (mst_bank[m] == BANK_SEL_W'(b));
      end
    end
  end

  for (genvar b = 0; b < NB_BANKS; b++) begin : gen_arb
    l2_rr_arbiter i_l2_rr_arbiter (
      .clk_i   ( clk_i        ),
      .rst_n_i ( rst_n_i      ),
      .req_i   ( bank_mreq[b] ),
      .gnt_o   ( bank_gnt[b]  )
    );
  end

  // A master targets one bank only, so the OR is one-hot per master
  always_comb begin
    gnt_o = '0;
    for (int unsigned b = 0; b < NB_BANKS; b++) begin
      gnt_o = gnt_o | bank_gnt[b];
    end
  end

  // Steer the winner's fields onto each bank
  always_comb begin
    bank_req_o   = '0;
    bank_wen_o   = '1;  // Idle banks see a read
    bank_addr_o  = '0;
    bank_wdata_o = '0;
    bank_be_o    = '0;
    gnt_idx      = '0;
    for (int unsigned b = 0; b < NB_BANKS; b++) begin
      for (int unsigned m = 0; m < N_MASTERS; m++) begin
        if (bank_gnt[b][m]) begin
          bank_req_o[b]   = 1'b1;
          bank_wen_o[b]   = wen_i[m];
          bank_addr_o[b]  = mst_row[m];
          bank_wdata_o[b] = wdata_i[m];
          bank_be_o[b]    = be_i[m];
          gnt_idx[b]      = MST_W'(m);
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= '0;
      rsp_read_q  <= '0;
      rsp_mst_q   <= '0;
    end else begin
      rsp_valid_q <= bank_req_o;
      rsp_read_q  <= bank_req_o & bank_wen_o;
      rsp_mst_q   <= gnt_idx;
    end
  end

  // Route bank read data back to the master granted last cycle
  always_comb begin
    r_valid_o = '0;
    r_rdata_o = '0;
    for (int unsigned b = 0; b < NB_BANKS; b++) begin
      if (rsp_valid_q[b]) begin
        r_valid_o[rsp_mst_q[b]] = 1'b1;
        if (rsp_read_q[b]) begin
          r_rdata_o[rsp_mst_q[b]] = bank_rdata_i[b];
        end  // Writes answer with zero data
      end
    end
  end

endmodule

`default_nettype wire

//--- l2_rr_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 round-robin arbiter
// Grants one requesting master per cycle for a single bank,
// searching upward from a rotating priority pointer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module l2_rr_arbiter (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  l2_pkg::master_vec_t req_i,
  output l2_pkg::master_vec_t gnt_o
);
  import l2_pkg::*;

  localparam int unsigned PTR_W = $clog2(N_MASTERS);

  logic [PTR_W-1:0] ptr_q;    // Highest priority master
  logic [PTR_W-1:0] gnt_idx;
  logic             gnt_any;

  // Index base + step, wrapped into the master range
  function automatic logic [PTR_W-1:0] wrap_add(input logic [PTR_W-1:0] base,
                                                input int unsigned      step);
    int unsigned sum;
    sum = int'(base) + step;
    if (sum >= N_MASTERS) begin
      sum = sum - N_MASTERS;
    end
    return PTR_W'(sum);
  endfunction

  // First requester at or after the pointer wins
  always_comb begin
    gnt_o   = '0;
    gnt_any = 1'b0;
    gnt_idx = ptr_q;
    for (int unsigned k = 0; k < N_MASTERS; k++) begin
      if (!gnt_any && req_i[wrap_add(ptr_q, k)]) begin
        gnt_any = 1'b1;
        gnt_idx = wrap_add(ptr_q, k);
      end
    end
    if (gnt_any) begin
      gnt_o[gnt_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (gnt_any) begin
      ptr_q <= wrap_add(gnt_idx, 1);  // Winner drops to lowest priority
    end
  end

endmodule

`default_nettype wire

//--- l2_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 scratchpad shared definitions
// Master counts, bus widths, window bases and vector types
// used by the crossbar, the banks and the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package l2_pkg;

  // Two 64-bit bridges split into 32-bit halves
  localparam int unsigned N_BRIDGE_PORTS = 4;
  localparam int unsigned N_UDMA_PORTS   = 2;  // uDMA channels
  localparam int unsigned N_MASTERS      = N_BRIDGE_PORTS + N_UDMA_PORTS;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [BE_W-1:0]      be_t;
  typedef logic [N_MASTERS-1:0] master_vec_t;  // Req, gnt and r_valid per master

  // Each master group sees the L2 at its own base
  localparam addr_t L2_BRIDGE_BASE = 32'h8000_0000;  // SoC memory map
  localparam addr_t L2_UDMA_BASE   = 32'h1C00_0000;  // Legacy uDMA view

endpackage

`default_nettype wire
